/* Bender.yml */
package:
  name: packet_playback

sources:
  # Design
  - common/playback_pkg.sv
  - hw/packet_mem.sv
  - packet_playback/playback_regs.sv
  - packet_playback/playback_engine.sv
  - packet_playback/packet_playback.sv

  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_packet_playback.sv

/* common/playback_pkg.sv */
`default_nettype none

package playback_pkg;

    // ========================================================================
    // Register port
    // ========================================================================
    localparam int REG_ADDR_WID = 4;
    localparam int REG_DATA_WID = 32;

    // Word offsets
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_SIZE    = 4'd0;
    localparam logic [REG_ADDR_WID-1:0] REG_META_WID    = 4'd1;
    localparam logic [REG_ADDR_WID-1:0] REG_CTRL        = 4'd2;
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS      = 4'd3;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_LEN     = 4'd4;
    localparam logic [REG_ADDR_WID-1:0] REG_META        = 4'd5;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_ADDR    = 4'd6;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_DATA_LO = 4'd7;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_DATA_HI = 4'd8;

    // ========================================================================
    // CTRL fields
    // ========================================================================
    localparam int CTRL_CMD_LSB   = 0;
    localparam int CTRL_CMD_WID   = 4;
    localparam int CTRL_BURST_LSB = 16;
    localparam int CTRL_BURST_WID = 16;

    localparam logic [CTRL_CMD_WID-1:0] CMD_NOP  = 4'd0;
    localparam logic [CTRL_CMD_WID-1:0] CMD_SEND = 4'd1;

    // STATUS bit positions
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;
    localparam int STAT_ERROR = 2;

endpackage

`default_nettype wire

/* hw/packet_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_mem #(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 1024,
    localparam int DEPTH    = PACKET_MEM_SIZE / DATA_BYTE_WID,
    localparam int ADDR_WID = $clog2(DEPTH),
    localparam int DATA_WID = DATA_BYTE_WID * 8
) (
    input  wire                 clk,
    input  wire                 wr,
    input  wire  [ADDR_WID-1:0] wr_addr,
    input  wire  [DATA_WID-1:0] wr_data,
    input  wire                 rd,
    input  wire  [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);

    // One beat per word, byte 0 in the top byte
    logic [DATA_WID-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (rd)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* packet_playback/packet_playback.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_playback
    import playback_pkg::*;
#(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 1024,
    parameter int META_WID        = 32,
    localparam int DATA_WID = DATA_BYTE_WID * 8,
    localparam int ADDR_WID = $clog2(PACKET_MEM_SIZE / DATA_BYTE_WID),
    localparam int LEN_WID  = $clog2(PACKET_MEM_SIZE + 1),
    localparam int MTY_WID  = $clog2(DATA_BYTE_WID)
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     en,
    input  wire                     reg_wr,
    input  wire                     reg_rd,
    input  wire  [REG_ADDR_WID-1:0] reg_addr,
    input  wire  [REG_DATA_WID-1:0] reg_wr_data,
    output logic [REG_DATA_WID-1:0] reg_rd_data,
    output logic                    out_valid,
    input  wire                     out_ready,
    output logic [DATA_WID-1:0]     out_data,
    output logic                    out_last,
    output logic [MTY_WID-1:0]      out_mty,
    output logic [META_WID-1:0]     out_meta
);

    // Buffer write side
    logic                      mem_wr;
    logic [ADDR_WID-1:0]       mem_wr_addr;
    logic [DATA_WID-1:0]       mem_wr_data;

    // Buffer read side
    logic                      mem_rd;
    logic [ADDR_WID-1:0]       mem_rd_addr;
    logic [DATA_WID-1:0]       mem_rd_data;

    // Command path
    logic                      cmd_send;
    logic [LEN_WID-1:0]        cfg_len;
    logic [META_WID-1:0]       cfg_meta;
    logic [CTRL_BURST_WID-1:0] cfg_burst;
    logic                      busy;
    logic                      done_pulse;

    playback_regs #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE),
        .META_WID        (META_WID)
    ) regs0 (.*);

    packet_mem #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) mem0 (
        .clk     (clk),
        .wr      (mem_wr),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd      (mem_rd),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

    playback_engine #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE),
        .META_WID        (META_WID)
    ) engine0 (.*);

endmodule

`default_nettype wire

/* packet_playback/playback_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module playback_engine
    import playback_pkg::*;
#(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 1024,
    parameter int META_WID        = 32,
    localparam int DATA_WID = DATA_BYTE_WID * 8,
    localparam int ADDR_WID = $clog2(PACKET_MEM_SIZE / DATA_BYTE_WID),
    localparam int LEN_WID  = $clog2(PACKET_MEM_SIZE + 1),
    localparam int MTY_WID  = $clog2(DATA_BYTE_WID)
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       en,
    input  wire                       cmd_send,
    input  wire  [LEN_WID-1:0]        cfg_len,
    input  wire  [META_WID-1:0]       cfg_meta,
    input  wire  [CTRL_BURST_WID-1:0] cfg_burst,
    output logic                      busy,
    output logic                      done_pulse,
    output logic                      mem_rd,
    output logic [ADDR_WID-1:0]       mem_rd_addr,
    input  wire  [DATA_WID-1:0]       mem_rd_data,
    output logic                      out_valid,
    output logic [DATA_WID-1:0]       out_data,
    output logic                      out_last,
    output logic [MTY_WID-1:0]        out_mty,
    output logic [META_WID-1:0]       out_meta,
    input  wire                       out_ready
);

    logic [META_WID-1:0]       meta_q;
    logic [ADDR_WID-1:0]       last_word;
    logic [MTY_WID-1:0]        last_mty;
    logic [CTRL_BURST_WID-1:0] pkts_left;
    logic [ADDR_WID-1:0]       rd_addr;
    logic                      issue;
    logic                      issue_last;
    logic                      issue_final;
    logic                      pop;
    logic [1:0]                occ;

    // Read in flight, tagged
    logic                      rd_pend;
    logic                      pend_last;
    logic                      pend_final;
    logic [MTY_WID-1:0]        pend_mty;

    // Skid entry behind the output register
    logic                      skid_valid;
    logic                      skid_last;
    logic                      skid_final;
    logic [MTY_WID-1:0]        skid_mty;
    logic [DATA_WID-1:0]       skid_data;
    logic                      out_final;

    // ========================================================================
    // Command latch and read sequencing
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            pkts_left <= '0;
            rd_addr   <= '0;
        end
        else if (cmd_send)
        begin
            busy      <= 1'b1;
            // Zero burst plays once
            pkts_left <= (cfg_burst == '0) ? CTRL_BURST_WID'(1) : cfg_burst;
            rd_addr   <= '0;
        end
        else
        begin
            if (done_pulse)
                busy <= 1'b0;
            if (issue)
            begin
                if (issue_last)
                begin
                    rd_addr   <= '0;
                    pkts_left <= pkts_left - 1'b1;
                end
                else
                    rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_send)
        begin
            meta_q    <= cfg_meta;
            last_word <= ADDR_WID'((cfg_len - 1'b1) / DATA_BYTE_WID);
            last_mty  <= MTY_WID'(DATA_BYTE_WID - 1 - (cfg_len - 1'b1) % DATA_BYTE_WID);
        end
    end

    // Output, skid and in-flight read share two slots
    assign pop  = out_valid && out_ready;
    assign occ  = 2'(out_valid) + 2'(skid_valid) + 2'(rd_pend) - 2'(pop);

    assign issue       = busy && en && (pkts_left != '0) && (occ < 2'd2);
    assign issue_last  = (rd_addr == last_word);
    assign issue_final = issue_last && (pkts_left == CTRL_BURST_WID'(1));

    assign mem_rd      = issue;
    assign mem_rd_addr = rd_addr;

    always_ff @(posedge clk)
    begin
        if (reset)
            rd_pend <= 1'b0;
        else
            rd_pend <= issue;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            pend_last  <= issue_last;
            pend_mty   <= issue_last ? last_mty : '0;
            pend_final <= issue_final;
        end
    end

    // ========================================================================
    // Output register and skid
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (!out_valid || pop)
        begin
            out_valid  <= skid_valid || rd_pend;
            skid_valid <= skid_valid && rd_pend;
        end
        else if (rd_pend)
            skid_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!out_valid || pop)
        begin
            // Skid is older than the arriving word
            if (skid_valid)
            begin
                out_data  <= skid_data;
                out_last  <= skid_last;
                out_mty   <= skid_mty;
                out_final <= skid_final;
            end
            else
            begin
                out_data  <= mem_rd_data;
                out_last  <= pend_last;
                out_mty   <= pend_mty;
                out_final <= pend_final;
            end
        end
        if (rd_pend && (skid_valid || (out_valid && !pop)))
        begin
            skid_data  <= mem_rd_data;
            skid_last  <= pend_last;
            skid_mty   <= pend_mty;
            skid_final <= pend_final;
        end
    end

    assign out_meta   = meta_q;
    assign done_pulse = pop && out_final;

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
            && $stable(out_mty) && $stable(out_meta));

    a_mty_last: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_last |-> out_mty == '0);

endmodule

`default_nettype wire

/* packet_playback/playback_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module playback_regs
    import playback_pkg::*;
#(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 1024,
    parameter int META_WID        = 32,
    localparam int DATA_WID = DATA_BYTE_WID * 8,
    localparam int ADDR_WID = $clog2(PACKET_MEM_SIZE / DATA_BYTE_WID),
    localparam int LEN_WID  = $clog2(PACKET_MEM_SIZE + 1)
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       reg_wr,
    input  wire                       reg_rd,
    input  wire  [REG_ADDR_WID-1:0]   reg_addr,
    input  wire  [REG_DATA_WID-1:0]   reg_wr_data,
    output logic [REG_DATA_WID-1:0]   reg_rd_data,
    output logic                      mem_wr,
    output logic [ADDR_WID-1:0]       mem_wr_addr,
    output logic [DATA_WID-1:0]       mem_wr_data,
    output logic                      cmd_send,
    output logic [LEN_WID-1:0]        cfg_len,
    output logic [META_WID-1:0]       cfg_meta,
    output logic [CTRL_BURST_WID-1:0] cfg_burst,
    input  wire                       busy,
    input  wire                       done_pulse
);

    logic [REG_DATA_WID-1:0] pkt_len;
    logic [META_WID-1:0]     meta;
    logic [ADDR_WID-1:0]     mem_addr;
    logic [REG_DATA_WID-1:0] data_lo;
    logic                    done;
    logic                    error;
    logic                    busy_any;
    logic                    ctrl_wr;
    logic [CTRL_CMD_WID-1:0] ctrl_cmd;
    logic                    len_ok;
    logic [REG_DATA_WID-1:0] status;

    // Pending cmd_send counts as busy so a second SEND cannot slip in
    assign busy_any = busy || cmd_send;
    assign ctrl_wr  = reg_wr && (reg_addr == REG_CTRL) && !busy_any;
    assign ctrl_cmd = reg_wr_data[CTRL_CMD_LSB +: CTRL_CMD_WID];
    assign len_ok   = (pkt_len != '0) && (pkt_len <= PACKET_MEM_SIZE);

    // ========================================================================
    // Configuration
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pkt_len  <= '0;
            meta     <= '0;
            mem_addr <= '0;
        end
        else if (reg_wr)
        begin
            case (reg_addr)
                REG_PKT_LEN:     pkt_len  <= reg_wr_data;
                REG_META:        meta     <= META_WID'(reg_wr_data);
                REG_MEM_ADDR:    mem_addr <= ADDR_WID'(reg_wr_data);
                // Auto-increment after each committed word
                REG_MEM_DATA_HI: mem_addr <= mem_addr + 1'b1;
                default:         ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reg_wr && (reg_addr == REG_MEM_DATA_LO))
            data_lo <= reg_wr_data;
    end

    // HI half carries the earlier packet bytes
    assign mem_wr      = reg_wr && (reg_addr == REG_MEM_DATA_HI);
    assign mem_wr_addr = mem_addr;
    assign mem_wr_data = DATA_WID'({reg_wr_data, data_lo});

    assign cfg_len  = LEN_WID'(pkt_len);
    assign cfg_meta = meta;

    // ========================================================================
    // Command and status
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmd_send  <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            cfg_burst <= '0;
        end
        else
        begin
            cmd_send <= 1'b0;
            if (ctrl_wr)
            begin
                done      <= 1'b0;
                error     <= 1'b0;
                cfg_burst <= reg_wr_data[CTRL_BURST_LSB +: CTRL_BURST_WID];
                case (ctrl_cmd)
                    CMD_NOP: done <= 1'b1;
                    CMD_SEND:
                    begin
                        // Bad length never reaches the engine
                        if (len_ok)
                            cmd_send <= 1'b1;
                        else
                        begin
                            error <= 1'b1;
                            done  <= 1'b1;
                        end
                    end
                    default:
                    begin
                        error <= 1'b1;
                        done  <= 1'b1;
                    end
                endcase
            end
            else if (done_pulse)
                done <= 1'b1;
        end
    end

    always_comb
    begin
        status             = '0;
        status[STAT_BUSY]  = busy_any;
        status[STAT_DONE]  = done;
        status[STAT_ERROR] = error;
    end

    // Read data holds until the next strobe
    always_ff @(posedge clk)
    begin
        if (reset)
            reg_rd_data <= '0;
        else if (reg_rd)
        begin
            case (reg_addr)
                REG_MEM_SIZE:    reg_rd_data <= REG_DATA_WID'(PACKET_MEM_SIZE);
                REG_META_WID:    reg_rd_data <= REG_DATA_WID'(META_WID);
                REG_STATUS:      reg_rd_data <= status;
                REG_PKT_LEN:     reg_rd_data <= pkt_len;
                REG_META:        reg_rd_data <= REG_DATA_WID'(meta);
                REG_MEM_ADDR:    reg_rd_data <= REG_DATA_WID'(mem_addr);
                REG_MEM_DATA_LO: reg_rd_data <= data_lo;
                default:         reg_rd_data <= '0;
            endcase
        end
    end

    // Software must not touch the buffer during playback
    a_no_mem_wr_busy: assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> !busy);

    // Engine idle for each command and takes it up the next cycle
    a_send_single: assert property (@(posedge clk) disable iff (reset)
        cmd_send |-> !busy ##1 (busy && !cmd_send));

endmodule

`default_nettype wire

/* verif/playback_tests.svh */
// ============================================================================
// Directed tests
// ============================================================================

task automatic check_info_regs();
    logic [31:0] value;
    test_name = "info";
    if (out_valid)
        report_failure("out_valid high after reset");
    reg_read(REG_MEM_SIZE, value);
    if (value != MEM_BYTES)
        report_mismatch("mem_size", MEM_BYTES, value);
    reg_read(REG_META_WID, value);
    if (value != META_BITS)
        report_mismatch("meta_wid", META_BITS, value);
endtask

task automatic nop_command();
    logic [31:0] status;
    test_name = "nop";
    clear_rx();
    issue_command(CMD_NOP, 0);
    wait_done(status);
    check_end_status(status, 1'b0);
    // Short window to catch a stray beat
    repeat (10) @(posedge clk);
    if (rx_beats != 0)
        report_mismatch("beats", 0, rx_beats);
endtask

task automatic single_packet();
    logic [31:0] status;
    logic [31:0] r;
    logic [31:0] meta;
    int          len;
    test_name = "single_packet";
    r    = rand_bits(8);
    len  = 1 + int'(r);
    meta = rand_bits(32);
    load_packet(len, meta);
    clear_rx();
    issue_command(CMD_SEND, 1);
    collect(1, 1'b0, 0);
    wait_done(status);
    check_end_status(status, 1'b0);
    check_stream(1);
endtask

task automatic packet_burst();
    logic [31:0] status;
    logic [31:0] r;
    logic [31:0] meta;
    int          len;
    test_name = "packet_burst";
    r    = rand_bits(8);
    len  = 1 + int'(r);
    meta = rand_bits(32);
    load_packet(len, meta);
    clear_rx();
    issue_command(CMD_SEND, 5);
    // Random back-pressure
    collect(5, 1'b1, 0);
    wait_done(status);
    check_end_status(status, 1'b0);
    check_stream(5);
endtask

task automatic bad_length();
    logic [31:0] status;
    logic [31:0] r;
    logic [31:0] meta;
    int          len;
    test_name = "bad_length";
    // Zero, then one byte past the buffer
    for (int i = 0; i < 2; i++)
    begin
        reg_write(REG_PKT_LEN, (i == 0) ? 0 : MEM_BYTES + 1);
        clear_rx();
        issue_command(CMD_SEND, 1);
        wait_done(status);
        check_end_status(status, 1'b1);
        repeat (10) @(posedge clk);
        if (rx_beats != 0)
            report_mismatch("beats", 0, rx_beats);
    end

    // A good SEND afterwards clears ERROR
    r    = rand_bits(8);
    len  = 1 + int'(r);
    meta = rand_bits(32);
    load_packet(len, meta);
    clear_rx();
    issue_command(CMD_SEND, 1);
    collect(1, 1'b1, 0);
    wait_done(status);
    check_end_status(status, 1'b0);
    check_stream(1);
endtask

task automatic pause_resume();
    logic [31:0] status;
    logic [31:0] r;
    logic [31:0] meta;
    int          len;
    test_name = "pause";
    // Long enough that the pause lands mid-burst
    r    = rand_bits(6);
    len  = 17 + int'(r);
    meta = rand_bits(32);
    load_packet(len, meta);
    clear_rx();
    issue_command(CMD_SEND, 4);
    collect(4, 1'b1, 3);
    wait_done(status);
    check_end_status(status, 1'b0);
    check_stream(4);
endtask

/* verif/tb_packet_playback.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_packet_playback
    import playback_pkg::*;
();

    // Matches the dut0 defaults
    localparam int DATA_BYTES    = 8;
    localparam int MEM_BYTES     = 1024;
    localparam int META_BITS     = 32;
    localparam int COLLECT_LIMIT = 20000;
    localparam int POLL_LIMIT    = 200;

    logic                    clk;
    logic                    reset;
    logic                    en;
    logic                    reg_wr;
    logic                    reg_rd;
    logic [REG_ADDR_WID-1:0] reg_addr;
    logic [REG_DATA_WID-1:0] reg_wr_data;
    logic [REG_DATA_WID-1:0] reg_rd_data;
    logic                    out_valid;
    logic                    out_ready;
    logic [63:0]             out_data;
    logic                    out_last;
    logic [2:0]              out_mty;
    logic [META_BITS-1:0]    out_meta;

    int          error_count;
    int          timeout_count;
    string       test_name;
    logic [31:0] lfsr_state;

    // Expected packet and what the monitor saw
    logic [7:0]  pkt_bytes[$];
    logic [7:0]  rx_bytes[$];
    int          rx_beats;
    int          rx_last_count;
    logic [31:0] exp_meta;
    logic [2:0]  exp_mty;

    packet_playback dut0 (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .reg_rd_data (reg_rd_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_mty     (out_mty),
        .out_meta    (out_meta)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // Random numbers
    // ========================================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ========================================================================
    // Reporting
    // ========================================================================
    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        error_count++;
    endtask

    // ========================================================================
    // Register access
    // ========================================================================
    task automatic reg_write(input logic [REG_ADDR_WID-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr      <= 1'b1;
        reg_addr    <= addr;
        reg_wr_data <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_WID-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd <= 1'b0;
        // Read data settles one cycle after the strobe
        @(negedge clk);
        data = reg_rd_data;
    endtask

    task automatic issue_command(input logic [3:0] cmd, input int burst);
        logic [31:0] word;
        word = '0;
        word[CTRL_CMD_LSB +: CTRL_CMD_WID]     = cmd;
        word[CTRL_BURST_LSB +: CTRL_BURST_WID] = burst[15:0];
        reg_write(REG_CTRL, word);
    endtask

    function automatic logic [7:0] byte_at(input int idx);
        return (idx < pkt_bytes.size()) ? pkt_bytes[idx] : 8'h00;
    endfunction

    // Fresh random packet, written big-endian into buffer words
    task automatic load_packet(input int len, input logic [31:0] meta);
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        int          base;
        pkt_bytes.delete();
        for (int i = 0; i < len; i++)
        begin
            r = rand_bits(8);
            pkt_bytes.push_back(r[7:0]);
        end
        exp_meta = meta;
        exp_mty  = 3'((DATA_BYTES - len % DATA_BYTES) % DATA_BYTES);
        reg_write(REG_PKT_LEN, len);
        reg_write(REG_META, meta);
        reg_write(REG_MEM_ADDR, 0);
        for (int k = 0; k < (len + DATA_BYTES - 1) / DATA_BYTES; k++)
        begin
            base = k * DATA_BYTES;
            hi = {byte_at(base), byte_at(base + 1), byte_at(base + 2), byte_at(base + 3)};
            lo = {byte_at(base + 4), byte_at(base + 5), byte_at(base + 6), byte_at(base + 7)};
            reg_write(REG_MEM_DATA_LO, lo);
            reg_write(REG_MEM_DATA_HI, hi);
        end
    endtask

    // ========================================================================
    // Stream side
    // ========================================================================
    always @(negedge clk)
    begin : stream_monitor
        int keep;
        if (!reset && out_valid && out_ready)
        begin
            keep = DATA_BYTES;
            if (out_last)
            begin
                rx_last_count++;
                if (out_mty != exp_mty)
                    report_mismatch("out_mty", exp_mty, out_mty);
                keep = DATA_BYTES - out_mty;
            end
            else if (out_mty != 3'd0)
                report_mismatch("out_mty", 0, out_mty);
            if (out_meta != exp_meta)
                report_mismatch("out_meta", exp_meta, out_meta);
            for (int i = 0; i < keep; i++)
                rx_bytes.push_back(out_data[8*(DATA_BYTES-1-i) +: 8]);
            rx_beats++;
        end
    end

    task automatic clear_rx();
        rx_bytes.delete();
        rx_beats      = 0;
        rx_last_count = 0;
    endtask

    // Held beats may still drain, nothing new may follow
    task automatic hold_pause();
        int start;
        en        <= 1'b0;
        out_ready <= 1'b1;
        start = rx_beats;
        repeat (50) @(posedge clk);
        @(negedge clk);
        if (rx_beats - start > 2)
            report_failure("more than two beats left the DUT while en was low");
        if (out_valid)
            report_failure("out_valid still high at the end of the pause");
        @(posedge clk);
        en <= 1'b1;
    endtask

    task automatic collect(input int n_last, input bit rand_ready, input int pause_at);
        int          cycles;
        bit          paused;
        logic [31:0] r;
        cycles = 0;
        paused = 1'b0;
        while (rx_last_count < n_last && cycles < COLLECT_LIMIT)
        begin
            @(posedge clk);
            r = rand_ready ? rand_bits(1) : 32'd1;
            out_ready <= r[0];
            cycles++;
            if (pause_at > 0 && !paused && rx_beats >= pause_at)
            begin
                paused = 1'b1;
                hold_pause();
            end
        end
        out_ready <= 1'b1;
        if (rx_last_count < n_last)
        begin
            $display("TIMEOUT %s: only %0d of %0d packets arrived", test_name,
                     rx_last_count, n_last);
            timeout_count++;
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[STAT_DONE] && polls < POLL_LIMIT)
        begin
            reg_read(REG_STATUS, status);
            polls++;
        end
        if (!status[STAT_DONE])
        begin
            $display("TIMEOUT %s: DONE did not rise", test_name);
            timeout_count++;
        end
    endtask

    task automatic check_end_status(input logic [31:0] status, input bit exp_error);
        if (status[STAT_ERROR] != exp_error)
            report_mismatch("error bit", exp_error, status[STAT_ERROR]);
        if (status[STAT_BUSY])
            report_failure("busy still set after DONE");
    endtask

    task automatic check_stream(input int copies);
        int len;
        len = pkt_bytes.size();
        if (rx_bytes.size() != len * copies)
            report_mismatch("byte count", len * copies, rx_bytes.size());
        else
        begin
            for (int i = 0; i < len * copies; i++)
            begin
                if (rx_bytes[i] != pkt_bytes[i % len])
                begin
                    report_mismatch($sformatf("byte %0d", i), pkt_bytes[i % len], rx_bytes[i]);
                    break;
                end
            end
        end
        if (rx_last_count != copies)
            report_mismatch("last flags", copies, rx_last_count);
    endtask

    `include "playback_tests.svh"

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        en            = 1'b1;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wr_data   = '0;
        out_ready     = 1'b1;
        error_count   = 0;
        timeout_count = 0;
        test_name     = "reset";
        exp_meta      = '0;
        exp_mty       = '0;
        lfsr_state    = 32'h018fa6f9;
        clear_rx();

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        check_info_regs();
        nop_command();
        single_packet();
        packet_burst();
        bad_length();
        pause_resume();

        $display("Errors: %0d  Timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
common/playback_pkg.sv
hw/packet_mem.sv
packet_playback/playback_regs.sv
packet_playback/playback_engine.sv
packet_playback/packet_playback.sv
verif/tb_packet_playback.sv
